/* hdl/udp_echo_defs.svh */
// Echo port and local IP are fixed at build time; FIFO depth must be a power of two
`ifndef UDP_ECHO_DEFS_SVH
`define UDP_ECHO_DEFS_SVH

// UDP destination port that gets answered
`define ECHO_PORT 16'd1234

// Local IPv4 address, 192.168.1.128
`define LOCAL_IP 32'hC0A8_0180

// Payload buffer entries between receive and transmit
`define PAYLOAD_FIFO_DEPTH 16

`endif

/* hdl/udp_echo_pkg.sv */
// Types shared by the echo core; the header struct carries only the UDP level fields
package udp_echo_pkg;

    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [7:0]  byte_t;

    // Same layout for received and reply headers
    typedef struct packed {
        ipv4_addr_t source_ip;
        ipv4_addr_t dest_ip;
        udp_port_t  source_port;
        udp_port_t  dest_port;
        logic [15:0] length;
    } udp_hdr_t;

    // One byte of payload plus framing
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;   // error flag, passed through untouched
    } payload_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        ECHO,
        DROP
    } echo_state_t;

endpackage

/* hdl/udp_echo_ctrl.sv */
// Every frame must carry at least one payload beat; a new header waits for the previous last beat
`timescale 1ns/1ps

`include "udp_echo_defs.svh"

module udp_echo_ctrl (
    input  logic                         clk,
    input  logic                         rst,

    input  udp_echo_pkg::udp_hdr_t       rx_hdr,
    input  logic                         rx_hdr_valid,
    output logic                         rx_hdr_ready,

    input  udp_echo_pkg::payload_beat_t  rx_payload,
    input  logic                         rx_payload_valid,
    output logic                         rx_payload_ready,

    output udp_echo_pkg::udp_hdr_t       tx_hdr,
    output logic                         tx_hdr_valid,
    input  logic                         tx_hdr_ready,

    output udp_echo_pkg::payload_beat_t  fifo_in,
    output logic                         fifo_in_valid,
    input  logic                         fifo_in_ready
);

    udp_echo_pkg::echo_state_t state;
    udp_echo_pkg::echo_state_t state_next;

    logic port_match;
    logic hdr_xfer;
    logic last_xfer;

    assign port_match = (rx_hdr.dest_port == `ECHO_PORT);

    // Reply header, ports swapped and answer goes back to the sender
    always_comb begin
        tx_hdr.source_ip   = `LOCAL_IP;
        tx_hdr.dest_ip     = rx_hdr.source_ip;
        tx_hdr.source_port = rx_hdr.dest_port;
        tx_hdr.dest_port   = rx_hdr.source_port;
        tx_hdr.length      = rx_hdr.length;
    end

    assign fifo_in = rx_payload;

    // Handshake steering per state
    always_comb begin
        rx_hdr_ready     = 1'b0;
        tx_hdr_valid     = 1'b0;
        rx_payload_ready = 1'b0;
        fifo_in_valid    = 1'b0;
        case (state)
            udp_echo_pkg::IDLE: begin
                // Non-matching headers are swallowed without waiting on tx
                rx_hdr_ready = !port_match || tx_hdr_ready;
                tx_hdr_valid = rx_hdr_valid && port_match;
            end
            udp_echo_pkg::ECHO: begin
                rx_payload_ready = fifo_in_ready;
                fifo_in_valid    = rx_payload_valid;
            end
            udp_echo_pkg::DROP: begin
                rx_payload_ready = 1'b1;
            end
            default: begin
                rx_hdr_ready = 1'b0;
            end
        endcase
    end

    assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
    assign last_xfer = rx_payload_valid && rx_payload_ready && rx_payload.last;

    always_comb begin
        state_next = state;
        case (state)
            udp_echo_pkg::IDLE: begin
                if (hdr_xfer) begin
                    state_next = port_match ? udp_echo_pkg::ECHO : udp_echo_pkg::DROP;
                end
            end
            udp_echo_pkg::ECHO,
            udp_echo_pkg::DROP: begin
                if (last_xfer) begin
                    state_next = udp_echo_pkg::IDLE;
                end
            end
            default: begin
                state_next = udp_echo_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_echo_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // A reply header only goes out while no payload is in flight
    a_no_hdr_in_payload: assert property (
        @(posedge clk) disable iff (rst)
        (hdr_xfer || (rx_payload_valid && rx_payload_ready && !rx_payload.last))
            |=> !tx_hdr_valid
    ) else $error("tx_hdr_valid high while a payload is in flight");

    // Dropped frames never reach the FIFO
    a_no_write_in_drop: assert property (
        @(posedge clk) disable iff (rst)
        ((hdr_xfer && !port_match)
            || (state == udp_echo_pkg::DROP && rx_payload_valid && !rx_payload.last))
            |=> !fifo_in_valid
    ) else $error("fifo_in_valid high while draining a dropped frame");

endmodule

/* hdl/axis_payload_fifo.sv */
// DEPTH must be a power of two; output is read straight from the storage array
`timescale 1ns/1ps

`include "udp_echo_defs.svh"

module axis_payload_fifo #(
    parameter int DEPTH = `PAYLOAD_FIFO_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,

    input  udp_echo_pkg::payload_beat_t  in_beat,
    input  logic                         in_valid,
    output logic                         in_ready,

    output udp_echo_pkg::payload_beat_t  out_beat,
    output logic                         out_valid,
    input  logic                         out_ready
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    udp_echo_pkg::payload_beat_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    logic wr_en;
    logic rd_en;

    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_beat  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy stays in range and agrees with the pointer distance
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        (count <= CW'(DEPTH)) && (count[AW-1:0] == wr_ptr - rd_ptr)
    ) else $error("FIFO occupancy above DEPTH");

    // Head beat must hold until the consumer takes it
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else $error("FIFO output changed while stalled");

endmodule

/* hdl/led_first_byte.sv */
// Watches the transmit payload only; a frame without a last beat keeps the LEDs frozen
`timescale 1ns/1ps

module led_first_byte (
    input  logic                         clk,
    input  logic                         rst,
    input  udp_echo_pkg::payload_beat_t  beat,
    input  logic                         valid,
    input  logic                         ready,
    output udp_echo_pkg::byte_t          led
);

    logic xfer;
    logic mid_frame;

    assign xfer = valid && ready;

    // Set after the first beat, cleared by the last one
    always_ff @(posedge clk) begin
        if (rst) begin
            mid_frame <= 1'b0;
        end else if (xfer) begin
            mid_frame <= !beat.last;
        end
    end

    // Latch the opening byte of each frame
    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
        end else if (xfer && !mid_frame) begin
            led <= beat.data;
        end
    end

endmodule

/* hdl/udp_echo_top.sv */
// Single clock domain; header out is combinational from header in, payload goes through a FIFO
`timescale 1ns/1ps

module udp_echo_top (
    input  logic                         clk,
    input  logic                         rst,

    // Received UDP frames
    input  udp_echo_pkg::udp_hdr_t       rx_hdr,
    input  logic                         rx_hdr_valid,
    output logic                         rx_hdr_ready,
    input  udp_echo_pkg::payload_beat_t  rx_payload,
    input  logic                         rx_payload_valid,
    output logic                         rx_payload_ready,

    // Reply frames
    output udp_echo_pkg::udp_hdr_t       tx_hdr,
    output logic                         tx_hdr_valid,
    input  logic                         tx_hdr_ready,
    output udp_echo_pkg::payload_beat_t  tx_payload,
    output logic                         tx_payload_valid,
    input  logic                         tx_payload_ready,

    output logic [7:0]                   led
);

    udp_echo_pkg::payload_beat_t fifo_in;
    logic                        fifo_in_valid;
    logic                        fifo_in_ready;

    udp_echo_ctrl ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .fifo_in          (fifo_in),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready)
    );

    axis_payload_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fifo_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_beat  (tx_payload),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready)
    );

    // LEDs follow the outgoing side
    led_first_byte led_i (
        .clk   (clk),
        .rst   (rst),
        .beat  (tx_payload),
        .valid (tx_payload_valid),
        .ready (tx_payload_ready),
        .led   (led)
    );

endmodule

/* test/tb_udp_echo.sv */
// Runs udp_echo_top with fixed LFSR stimulus; every frame carries 1 to 24 payload beats
`timescale 1ns/1ps

`include "udp_echo_defs.svh"

module tb_udp_echo;

    localparam int MAX_FRAMES       = 20;
    localparam int CYCLES_PER_FRAME = 64;
    localparam int RESET_CYCLES     = 5;
    localparam int TIMEOUT_CYCLES   = MAX_FRAMES * CYCLES_PER_FRAME + RESET_CYCLES;

    logic                        clk;
    logic                        rst;
    udp_echo_pkg::udp_hdr_t      rx_hdr;
    logic                        rx_hdr_valid;
    logic                        rx_hdr_ready;
    udp_echo_pkg::payload_beat_t rx_payload;
    logic                        rx_payload_valid;
    logic                        rx_payload_ready;
    udp_echo_pkg::udp_hdr_t      tx_hdr;
    logic                        tx_hdr_valid;
    logic                        tx_hdr_ready;
    udp_echo_pkg::payload_beat_t tx_payload;
    logic                        tx_payload_valid;
    logic                        tx_payload_ready;
    logic [7:0]                  led;

    // Reference model state
    udp_echo_pkg::payload_beat_t exp_q [$];
    udp_echo_pkg::payload_beat_t exp_head;
    udp_echo_pkg::udp_hdr_t      exp_hdr;
    int                          exp_count;
    logic [7:0]                  exp_led;
    logic                        out_mid;
    logic                        frame_echo;
    logic                        quiet;
    logic                        full_seen;
    logic                        hdr_took;
    logic                        beat_took;

    // tx ready pattern control
    int                          hold_cycles;
    logic                        random_ready;

    logic [31:0]                 lfsr;
    int                          cycle_count;
    int                          errors;
    int                          errors_mark;
    int                          tests_run;
    int                          tests_failed;

    udp_echo_top dut_i (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr           (rx_hdr),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_payload       (rx_payload),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr           (tx_hdr),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_payload       (tx_payload),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

    always #20 clk = ~clk;

    // Galois form, taps for x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic udp_echo_pkg::udp_port_t other_port();
        udp_echo_pkg::udp_port_t p;
        p = 16'(random_bits(16));
        if (p == `ECHO_PORT) begin
            p = p ^ 16'h0001;
        end
        return p;
    endfunction

    // Reply goes back to the sender with ports swapped
    function automatic udp_echo_pkg::udp_hdr_t reply_for(input udp_echo_pkg::udp_hdr_t h);
        udp_echo_pkg::udp_hdr_t r;
        r.source_ip   = `LOCAL_IP;
        r.dest_ip     = h.source_ip;
        r.source_port = h.dest_port;
        r.dest_port   = h.source_port;
        r.length      = h.length;
        return r;
    endfunction

    always @(negedge clk) begin
        if (hold_cycles > 0) begin
            tx_payload_ready = 1'b0;
            tx_hdr_ready     = 1'b1;
            hold_cycles      = hold_cycles - 1;
        end else if (random_ready) begin
            tx_payload_ready = random_bits(1)
                               ? 1'b1 : 1'b0;
            tx_hdr_ready     = random_bits(1) ? 1'b1 : 1'b0;
        end else begin
            tx_payload_ready = 1'b1;
            tx_hdr_ready     = 1'b1;
        end
    end

    // Track handshakes and keep the expected beat queue
    always @(posedge clk) begin : monitor
        udp_echo_pkg::payload_beat_t head;
        if (rst) begin
            exp_q.delete();
            out_mid   = 1'b0;
            exp_head  <= '0;
            exp_count <= 0;
            exp_led   <= 8'h00;
        end else begin
            if (tx_payload_valid && tx_payload_ready && exp_q.size() != 0) begin
                head = exp_q.pop_front();
                if (!out_mid) begin
                    exp_led <= head.data;
                end
                out_mid = !head.last;
            end
            if (rx_payload_valid && rx_payload_ready && frame_echo) begin
                exp_q.push_back(rx_payload);
            end
            if (rx_payload_valid && frame_echo && exp_count == `PAYLOAD_FIFO_DEPTH) begin
                full_seen <= 1'b1;
            end
            if (exp_q.size() != 0) begin
                exp_head <= exp_q[0];
            end else begin
                exp_head <= '0;
            end
            exp_count <= exp_q.size();
        end
        hdr_took  <= rx_hdr_valid && rx_hdr_ready;
        beat_took <= rx_payload_valid && rx_payload_ready;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    a_quiet: assert property (@(posedge clk)
        quiet |-> (!tx_hdr_valid && !tx_payload_valid && led == 8'h00)
    ) else begin
        errors++;
        $display("MISMATCH tx_hdr_valid/tx_payload_valid/led got %h %h %h expected 0 0 00",
                 $sampled(tx_hdr_valid), $sampled(tx_payload_valid), $sampled(led));
    end

    a_hdr_valid: assert property (@(posedge clk) disable iff (rst)
        (rx_hdr_valid && frame_echo) |-> tx_hdr_valid
    ) else begin
        errors++;
        $display("MISMATCH tx_hdr_valid got %h expected 1", $sampled(tx_hdr_valid));
    end

    a_hdr_stall: assert property (@(posedge clk) disable iff (rst)
        (rx_hdr_valid && frame_echo) |-> (rx_hdr_ready == tx_hdr_ready)
    ) else begin
        errors++;
        $display("MISMATCH rx_hdr_ready got %h expected %h",
                 $sampled(rx_hdr_ready), $sampled(tx_hdr_ready));
    end

    a_hdr_fields: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid |-> (tx_hdr == exp_hdr)
    ) else begin
        errors++;
        $display("MISMATCH tx_hdr got %h expected %h", $sampled(tx_hdr), $sampled(exp_hdr));
    end

    a_no_stray_hdr: assert property (@(posedge clk) disable iff (rst)
        !(rx_hdr_valid && frame_echo) |-> !tx_hdr_valid
    ) else begin
        errors++;
        $display("MISMATCH tx_hdr_valid got %h expected 0", $sampled(tx_hdr_valid));
    end

    a_drop_hdr_taken: assert property (@(posedge clk) disable iff (rst)
        (rx_hdr_valid && !frame_echo) |-> rx_hdr_ready
    ) else begin
        errors++;
        $display("MISMATCH rx_hdr_ready got %h expected 1", $sampled(rx_hdr_ready));
    end

    a_beat_expected: assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid |-> (exp_count != 0)
    ) else begin
        errors++;
        $display("Beat appeared on tx_payload with no echoed beat outstanding");
    end

    a_beat_value: assert property (@(posedge clk) disable iff (rst)
        (tx_payload_valid && exp_count != 0) |-> (tx_payload == exp_head)
    ) else begin
        errors++;
        $display("MISMATCH tx_payload got %h expected %h",
                 $sampled(tx_payload), $sampled(exp_head));
    end

    a_drop_drain: assert property (@(posedge clk) disable iff (rst)
        (rx_payload_valid && !frame_echo) |-> rx_payload_ready
    ) else begin
        errors++;
        $display("MISMATCH rx_payload_ready got %h expected 1", $sampled(rx_payload_ready));
    end

    // Ready must track free space in the 16 entry buffer
    a_fill_ready: assert property (@(posedge clk) disable iff (rst)
        (rx_payload_valid && frame_echo)
            |-> (rx_payload_ready == (exp_count < `PAYLOAD_FIFO_DEPTH))
    ) else begin
        errors++;
        $display("MISMATCH rx_payload_ready got %h expected %h", $sampled(rx_payload_ready),
                 $sampled(exp_count < `PAYLOAD_FIFO_DEPTH));
    end

    a_led: assert property (@(posedge clk) disable iff (rst)
        led == exp_led
    ) else begin
        errors++;
        $display("MISMATCH led got %h expected %h", $sampled(led), $sampled(exp_led));
    end

    // Called on a falling edge; returns on the falling edge after the last beat
    task automatic send_frame(input logic echo, input int len);
        udp_echo_pkg::udp_hdr_t      h;
        udp_echo_pkg::payload_beat_t b;
        h.source_ip   = random_bits(32);
        h.dest_ip     = `LOCAL_IP;
        h.source_port = 16'(random_bits(16));
        h.dest_port   = echo ? `ECHO_PORT : other_port();
        h.length      = 16'(8 + len);
        rx_hdr       = h;
        rx_hdr_valid = 1'b1;
        frame_echo   = echo;
        exp_hdr      = reply_for(h);
        do @(negedge clk); while (!hdr_took);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            b.data = 8'(random_bits(8));
            b.last = (i == len - 1);
            b.user = random_bits(1) ? 1'b1 : 1'b0;
            rx_payload       = b;
            rx_payload_valid = 1'b1;
            do @(negedge clk); while (!beat_took);
        end
        rx_payload_valid = 1'b0;
    endtask

    function automatic int random_len();
        return 1 + int'(random_bits(5)) % 24;
    endfunction

    task automatic wait_drain();
        while (exp_count != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // Mode changes land on a rising edge so the ready driver sees them next falling edge
    task automatic set_tx_mode(input int hold, input logic rnd);
        @(posedge clk);
        hold_cycles  = hold;
        random_ready = rnd;
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != errors_mark) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errors_mark);
        end else begin
            $display("test %s: ok", name);
        end
        errors_mark = errors;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rx_hdr = '0;
        rx_hdr_valid = 1'b0;
        rx_payload = '0;
        rx_payload_valid = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_payload_ready = 1'b1;
        exp_hdr = '0;
        frame_echo = 1'b0;
        quiet = 1'b0;
        full_seen = 1'b0;
        hold_cycles = 0;
        random_ready = 1'b0;
        lfsr = 32'hb585;
        cycle_count = 0;
        errors = 0;
        errors_mark = 0;
        tests_run = 0;
        tests_failed = 0;

        // First edge skipped since register contents are still unknown there
        @(negedge clk);
        quiet = 1'b1;
        repeat (RESET_CYCLES - 1) @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);
        quiet = 1'b0;
        finish_test("reset");

        for (int f = 0; f < 4; f++) begin
            send_frame(1'b1, random_len());
        end
        wait_drain();
        finish_test("echo");

        for (int f = 0; f < 2; f++) begin
            send_frame(1'b0, random_len());
        end
        wait_drain();
        finish_test("drop");

        set_tx_mode(30, 1'b0);
        send_frame(1'b1, 24);
        wait_drain();
        assert (full_seen) else begin
            errors++;
            $display("FIFO never filled up while tx_payload_ready was held low");
        end
        finish_test("fifo_full");

        set_tx_mode(0, 1'b1);
        for (int f = 0; f < 8; f++) begin
            send_frame(random_bits(1) != 0, random_len());
        end
        set_tx_mode(0, 1'b0);
        wait_drain();
        finish_test("random_ready");

        for (int f = 0; f < 3; f++) begin
            send_frame(1'b1, random_len());
            wait_drain();
        end
        finish_test("led");

        $display("tests %0d, failed %0d, assertion errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* udp_echo.f */
+incdir+hdl
hdl/udp_echo_pkg.sv
hdl/udp_echo_ctrl.sv
hdl/axis_payload_fifo.sv
hdl/led_first_byte.sv
hdl/udp_echo_top.sv
test/tb_udp_echo.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status 1 unless the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_udp_echo \
    -f udp_echo.f -o sim_udp_echo &&
out="$(./obj_dir/sim_udp_echo)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "Regression passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
